// File: design/pim_mem_pkg.sv
/*
 * pim memory package
 * widths and vector types for the bank words and addresses
 * and for the leaf RAM blocks that the bank is built from
 */
`default_nettype none

package pim_mem_pkg;

    localparam int BANK_ADDR_W = 10;  // 1024 words in the bank
    localparam int LEAF_ADDR_W = 8;   // 256 entries in one leaf block
    localparam int DATA_W      = 16;  // width of one bank word

    // word address anywhere in the bank
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

    typedef logic [LEAF_ADDR_W-1:0] leaf_addr_t;  // address into one leaf block

    // data word, fetch-and-add operand or response
    typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// File: design/pim_cmd_pkg.sv
/*
 * pim command package
 * operation codes of the command port and the states
 * of the controller FSM
 */
`default_nettype none

package pim_cmd_pkg;

    // every operation responds with the old word of the address
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,  // word is left unchanged
        OP_WRITE = 2'd1,  // operand replaces the word
        OP_ADD   = 2'd2   // word plus operand is written back
    } pim_op_t;

    // one command in flight from accept to response
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // waiting for a command
        ST_LOAD = 2'd1,  // old word arrives from the memory
        ST_RESP = 2'd2   // response offered until taken
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/single_port_ram.sv
/*
 * single port leaf RAM
 * one bit wide and read-first with a registered output
 * that models the hard RAM block of the bank
 */
`timescale 1ns/1ps
`default_nettype none

module single_port_ram (
    input  logic                    clk,
    input  logic                    we,
    input  pim_mem_pkg::leaf_addr_t addr,
    input  logic                    data,
    output logic                    out
);

    import pim_mem_pkg::*;

    logic mem [2**LEAF_ADDR_W];  // contents are never reset

    // the old bit is registered before a write replaces it
    always_ff @(posedge clk) begin
        out <= mem[addr];
        if (we) begin
            mem[addr] <= data;
        end
    end

endmodule

`default_nettype wire

// File: design/memory_split.sv
/*
 * recursive memory splitter
 * halves the depth until the address fits a leaf block
 * and then places one 1-bit leaf RAM per data bit
 */
`timescale 1ns/1ps
`default_nettype none

module memory_split #(
    parameter int ADDR_WIDTH = pim_mem_pkg::BANK_ADDR_W,
    parameter int DATA_WIDTH = pim_mem_pkg::DATA_W
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] out
);

    import pim_mem_pkg::*;

    generate
        if (ADDR_WIDTH > LEAF_ADDR_W) begin : g_depth
            logic [ADDR_WIDTH-2:0] sub_addr;
            logic [DATA_WIDTH-1:0] out_h;
            logic [DATA_WIDTH-1:0] out_l;
            logic                  we_h;
            logic                  we_l;
            logic                  sel_q;

            assign sub_addr = addr[ADDR_WIDTH-2:0];
            assign we_h     = we & addr[ADDR_WIDTH-1];   // only the addressed half is written
            assign we_l     = we & ~addr[ADDR_WIDTH-1];

            memory_split #(
                .ADDR_WIDTH(ADDR_WIDTH-1),
                .DATA_WIDTH(DATA_WIDTH)
            ) u_high (
                .clk (clk),
                .we  (we_h),
                .addr(sub_addr),
                .data(data),
                .out (out_h)
            );

            memory_split #(
                .ADDR_WIDTH(ADDR_WIDTH-1),
                .DATA_WIDTH(DATA_WIDTH)
            ) u_low (
                .clk (clk),
                .we  (we_l),
                .addr(sub_addr),
                .data(data),
                .out (out_l)
            );

            // select bit lines up with the registered leaf outputs
            always_ff @(posedge clk) begin
                sel_q <= addr[ADDR_WIDTH-1];
            end

            assign out = sel_q ? out_h : out_l;
        end else begin : g_width
            leaf_addr_t leaf_addr;

            assign leaf_addr = leaf_addr_t'(addr);  // upper leaf bits padded with zeros

            for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_bit
                single_port_ram u_leaf (
                    .clk (clk),
                    .we  (we),
                    .addr(leaf_addr),
                    .data(data[i]),
                    .out (out[i])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/pim_controller.sv
/*
 * pim command controller
 * runs read, write and fetch-and-add one command at a time
 * and answers each with the old word of the address
 */
`timescale 1ns/1ps
`default_nettype none

module pim_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  pim_cmd_pkg::pim_op_t    cmd_op,
    input  pim_mem_pkg::bank_addr_t cmd_addr,
    input  pim_mem_pkg::data_t      cmd_data,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output pim_mem_pkg::data_t      rsp_data,
    output logic                    mem_we,
    output pim_mem_pkg::bank_addr_t mem_addr,
    output pim_mem_pkg::data_t      mem_wdata,
    input  pim_mem_pkg::data_t      mem_rdata
);

    import pim_mem_pkg::*;
    import pim_cmd_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    pim_op_t     op_q;
    bank_addr_t  addr_q;
    data_t       operand_q;
    data_t       rsp_data_q;
    data_t       sum;
    logic        accept;

    assign accept = cmd_valid & cmd_ready;
    assign sum    = mem_rdata + operand_q;  // wraps modulo 2**DATA_W

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOAD;
                end
            end
            ST_LOAD: state_d = ST_RESP;  // old word is on mem_rdata this cycle
            ST_RESP: begin
                if (rsp_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // hold the accepted command for the write-back cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= cmd_op;
            addr_q    <= cmd_addr;
            operand_q <= cmd_data;
        end
    end

    // the response holds its value under back-pressure
    always_ff @(posedge clk) begin
        if (state_q == ST_LOAD) begin
            rsp_data_q <= mem_rdata;
        end
    end

    // idle cycles address the memory straight from the command port
    always_comb begin
        mem_we    = 1'b0;
        mem_addr  = addr_q;
        mem_wdata = operand_q;
        if (state_q == ST_IDLE) begin
            mem_we    = cmd_valid & (cmd_op == OP_WRITE);
            mem_addr  = cmd_addr;
            mem_wdata = cmd_data;
        end else if (state_q == ST_LOAD) begin
            mem_we    = (op_q == OP_ADD);  // sum goes back to the held address
            mem_wdata = sum;
        end
    end

    assign cmd_ready = (state_q == ST_IDLE);
    assign rsp_valid = (state_q == ST_RESP);
    assign rsp_data  = rsp_data_q;

endmodule

`default_nettype wire

// File: design/pim_bank_top.sv
/*
 * pim bank top level
 * joins the command controller to the split memory
 * built from 1-bit leaf RAM blocks
 */
`timescale 1ns/1ps
`default_nettype none

module pim_bank_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  pim_cmd_pkg::pim_op_t    cmd_op,
    input  pim_mem_pkg::bank_addr_t cmd_addr,
    input  pim_mem_pkg::data_t      cmd_data,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output pim_mem_pkg::data_t      rsp_data
);

    import pim_mem_pkg::*;

    logic       mem_we;
    bank_addr_t mem_addr;
    data_t      mem_wdata;
    data_t      mem_rdata;  // valid one cycle after the address edge

    pim_controller u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_data (rsp_data),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    memory_split #(
        .ADDR_WIDTH(BANK_ADDR_W),
        .DATA_WIDTH(DATA_W)
    ) u_mem (
        .clk (clk),
        .we  (mem_we),
        .addr(mem_addr),
        .data(mem_wdata),
        .out (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verif/pim_bank_checker.sv
/*
 * pim controller checker
 * handshake and latency assertions bound into the command controller
 */
`timescale 1ns/1ps
`default_nettype none

module pim_bank_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     cmd_valid,
    input logic                     cmd_ready,
    input logic                     rsp_valid,
    input logic                     rsp_ready,
    input pim_mem_pkg::data_t       rsp_data
);

    int fail_count = 0;  // summed into the testbench result at the end of the run

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
        else begin
            fail_count++;
            $error("response changed while rsp_ready was low");
        end

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_ready && rsp_valid))
        else begin
            fail_count++;
            $error("cmd_ready and rsp_valid high together");
        end

    // every response is preceded by an accept two edges earlier
    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> $past(cmd_valid && cmd_ready, 2))
        else begin
            fail_count++;
            $error("rsp_valid rose without an accept two cycles earlier");
        end

endmodule

bind pim_controller pim_bank_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_data (rsp_data)
);

`default_nettype wire

// File: verif/pim_bank_tb.sv
/*
 * pim bank testbench
 * replays the commands of the testdata file against the bank, checks each
 * response against the file and a scoreboard, and measures the latency
 */
`timescale 1ns/1ps
`default_nettype none

module pim_bank_tb;

    import pim_mem_pkg::*;
    import pim_cmd_pkg::*;

    localparam int          MAX_CMDS = 64;
    localparam int          FIELDS   = 5;   // op, addr, operand, expected, stall
    localparam int          TIMEOUT  = 50;  // cycles allowed for any wait
    localparam int          LATENCY  = 2;
    localparam int unsigned SEED     = 32'h222357cf;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cmd_valid;
    logic       cmd_ready;
    pim_op_t    cmd_op;
    bank_addr_t cmd_addr;
    data_t      cmd_data;
    logic       rsp_valid;
    logic       rsp_ready;
    data_t      rsp_data;

    logic [15:0] vec [0:MAX_CMDS*FIELDS-1];
    data_t       sb_mem [0:2**BANK_ADDR_W-1];    // expected contents by the op rules
    logic        sb_known [0:2**BANK_ADDR_W-1];
    int          errors;
    int          num_cmds;
    logic        hung;

    pim_bank_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_data (rsp_data)
    );

    always #5 clk = ~clk;

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Fail %s latency expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic wait_cmd_ready(input string name);
        int cycles;
        cycles = 0;
        while (!hung) begin
            @(negedge clk);
            if (cmd_ready) begin
                break;
            end
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_problem({name, ": timed out waiting for cmd_ready"});
                hung = 1'b1;
            end
        end
    endtask

    // counts falling edges from the accept edge up to the first valid response
    task automatic wait_rsp_valid(input string name, output int cycles);
        cycles = 0;
        while (!hung) begin
            @(negedge clk);
            cycles++;
            if (rsp_valid) begin
                break;
            end
            if (cycles >= TIMEOUT) begin
                report_problem({name, ": timed out waiting for rsp_valid"});
                hung = 1'b1;
            end
        end
    endtask

    task automatic run_command(input int idx);
        pim_op_t    op;
        bank_addr_t addr;
        data_t      operand;
        data_t      expected;
        data_t      first;
        data_t      old_word;
        int         stall;
        int         gap;
        int         cycles;
        string      name;
        op       = pim_op_t'(vec[idx*FIELDS][1:0]);
        addr     = bank_addr_t'(vec[idx*FIELDS+1]);
        operand  = data_t'(vec[idx*FIELDS+2]);
        expected = data_t'(vec[idx*FIELDS+3]);
        stall    = int'(vec[idx*FIELDS+4]);
        name     = $sformatf("cmd %0d %s @%h", idx, op.name(), addr);
        gap      = $urandom % 4;
        repeat (gap) @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_data  <= operand;
        wait_cmd_ready(name);
        if (hung) begin
            return;
        end
        @(posedge clk);  // accept edge
        cmd_valid <= 1'b0;
        rsp_ready <= (stall == 0);
        wait_rsp_valid(name, cycles);
        if (hung) begin
            return;
        end
        check_latency(name, LATENCY, cycles);
        first    = rsp_data;
        old_word = sb_mem[addr];
        if (sb_known[addr]) begin  // the first write of an address sees undefined contents
            check_data({name, " vs file"}, expected, first);
            check_data({name, " vs model"}, old_word, first);
        end
        if (op == OP_WRITE) begin
            sb_mem[addr]   = operand;
            sb_known[addr] = 1'b1;
        end else if (op == OP_ADD) begin
            sb_mem[addr] = old_word + operand;
        end
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            if (i == stall - 1) begin
                rsp_ready <= 1'b1;
            end
            @(negedge clk);
            if (!rsp_valid) begin
                report_problem({name, ": rsp_valid dropped while rsp_ready was low"});
            end
            if (cmd_ready) begin
                report_problem({name, ": cmd_ready rose while a response was pending"});
            end
            check_data({name, " hold"}, first, rsp_data);
        end
        @(posedge clk);  // response transfers here
        rsp_ready <= 1'b0;
    endtask

    initial begin
        int assert_fails;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_READ;
        cmd_addr  = '0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        errors    = 0;
        num_cmds  = 0;
        hung      = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < MAX_CMDS*FIELDS; i++) begin
            vec[i] = 16'hffff;  // marks the end of the command list
        end
        for (int a = 0; a < 2**BANK_ADDR_W; a++) begin
            sb_mem[a]   = '0;
            sb_known[a] = 1'b0;
        end
        $readmemh("verif/pim_testdata.txt", vec);
        while (num_cmds < MAX_CMDS && vec[num_cmds*FIELDS] != 16'hffff) begin
            num_cmds++;
        end
        if (num_cmds == 0) begin
            report_problem("no commands found in the testdata file");
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (rsp_valid) begin
            report_problem("rsp_valid is high during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (rsp_valid || !cmd_ready) begin
            report_problem("controller is not idle after reset");
        end
        @(posedge clk);
        for (int n = 0; n < num_cmds; n++) begin
            run_command(n);
            if (hung) begin
                break;
            end
        end
        assert_fails = UUT.u_ctrl.u_checker.fail_count;
        $display("%0d commands, %0d errors, %0d assertion failures",
                 num_cmds, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pim_testdata.txt
// columns: op addr operand expected stall (hex), op 0 read, 1 write, 2 fetch-and-add
// expected is the old word and is ignored until the address has been written once
1 012 1111 0000 0
1 112 2222 0000 0
1 212 3333 0000 1
1 312 4444 0000 0
0 012 0000 1111 0
0 112 0000 2222 2
0 212 0000 3333 0
0 312 0000 4444 0
1 012 aaaa 1111 0
0 012 0000 aaaa 0
1 3ff fff0 0000 0
2 3ff 0025 fff0 0
0 3ff 0000 0015 3
2 112 0101 2222 0
0 112 0000 2323 0
0 012 0000 aaaa 0
1 000 beef 0000 4
2 000 1111 beef 0
2 000 ffff d000 1
0 000 0000 cfff 0
1 200 5a5a 0000 0
0 000 0000 cfff 0
0 200 0000 5a5a 2
1 312 0000 4444 0
0 312 0000 0000 0
0 212 0000 3333 0
2 212 cccd 3333 0
0 212 0000 0000 1

// File: vlog.f
design/pim_mem_pkg.sv
design/pim_cmd_pkg.sv
design/single_port_ram.sv
design/memory_split.sv
design/pim_controller.sv
design/pim_bank_top.sv
verif/pim_bank_checker.sv
verif/pim_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the pim bank testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module pim_bank_tb -f vlog.f -o pim_bank_sim

./obj_dir/pim_bank_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
